//--- source/uart_tx_pkg.sv
`default_nettype none

package uart_tx_pkg;

    // Character format
    localparam int DATA_WIDTH = 8;

    // Start bit, data bits and stop bit
    localparam int FRAME_BITS = DATA_WIDTH + 2;

    // Transmit FIFO geometry
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);

    // Fill level that raises almost_full
    localparam int ALMOST_FULL_LEVEL = 14;

    // Bit period in clocks, and the width of the counter that times it
    localparam int CLKS_PER_BIT = 16;
    localparam int BIT_CNT_WIDTH = 4;

    // Frame sequencer states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } tx_state_t;

endpackage

`default_nettype wire

//--- source/uart_tx_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx_fifo
    import uart_tx_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,

    // Write side
    input  logic                  wr_en,
    input  logic [DATA_WIDTH-1:0] wr_data,

    // Read side, first word falls through
    input  logic                  rd_en,
    output logic [DATA_WIDTH-1:0] rd_data,

    // Status
    output logic                  full,
    output logic                  almost_full,
    output logic                  empty
);

    logic [DATA_WIDTH-1:0]     mem [FIFO_DEPTH];
    logic [FIFO_PTR_WIDTH-1:0] wr_ptr;
    logic [FIFO_PTR_WIDTH-1:0] rd_ptr;
    logic [FIFO_PTR_WIDTH:0]   count;

    logic wr_accept;
    logic rd_accept;

    // Drop writes when full, ignore pops when empty
    assign wr_accept = wr_en & ~full;
    assign rd_accept = rd_en & ~empty;

    // Storage array
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_accept) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_accept) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else begin
            case ({wr_accept, rd_accept})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Oldest entry is always on the output
    assign rd_data = mem[rd_ptr];

    // Flags decoded from the registered count
    assign empty       = (count == '0);
    assign full        = (count == (FIFO_PTR_WIDTH + 1)'(FIFO_DEPTH));
    assign almost_full = (count >= (FIFO_PTR_WIDTH + 1)'(ALMOST_FULL_LEVEL));

endmodule

`default_nettype wire

//--- source/uart_baud_timer.sv
`timescale 1ns/1ps
`default_nettype none

module uart_baud_timer
    import uart_tx_pkg::*;
(
    input  logic clk,
    input  logic arst_n,
    input  logic restart,
    output logic bit_tick
);

    logic [BIT_CNT_WIDTH-1:0] count;

    // Counting down from the reload value reaches zero after one full bit period
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= BIT_CNT_WIDTH'(CLKS_PER_BIT - 1);
        end else if (restart || bit_tick) begin
            count <= BIT_CNT_WIDTH'(CLKS_PER_BIT - 1);
        end else begin
            count <= count - 1'b1;
        end
    end

    // Last cycle of every bit period
    assign bit_tick = (count == '0);

endmodule

`default_nettype wire

//--- source/uart_tx_controller.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx_controller
    import uart_tx_pkg::*;
(
    input  logic clk,
    input  logic arst_n,

    // User permission and FIFO status
    input  logic tx_valid,
    input  logic empty,

    // Bit boundary from the baud timer
    input  logic bit_tick,

    // Datapath control
    output logic fifo_pop,
    output logic shift_en,

    // Status
    output logic tx_ready,
    output logic tx_busy,
    output logic tx_done
);

    tx_state_t state;
    tx_state_t state_next;

    // Position of the current bit within the frame, start bit is 0
    logic [$clog2(FRAME_BITS)-1:0] bit_idx;
    logic                          last_data;

    assign last_data = (bit_idx == ($clog2(FRAME_BITS))'(FRAME_BITS - 2));

    // A new frame only begins from idle
    assign fifo_pop = (state == ST_IDLE) & tx_valid & ~empty;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (fifo_pop) begin
                    state_next = ST_START;
                end
            end
            ST_START: begin
                if (bit_tick) begin
                    state_next = ST_DATA;
                end
            end
            ST_DATA: begin
                if (bit_tick && last_data) begin
                    state_next = ST_STOP;
                end
            end
            ST_STOP: begin
                if (bit_tick) begin
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Bit position advances on every tick inside a frame
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bit_idx <= '0;
        end else if (fifo_pop) begin
            bit_idx <= '0;
        end else if (bit_tick && state != ST_IDLE) begin
            bit_idx <= bit_idx + 1'b1;
        end
    end

    assign shift_en = (state != ST_IDLE);
    assign tx_ready = (state == ST_IDLE);
    assign tx_busy  = (state != ST_IDLE);

    // Final cycle of the stop bit
    assign tx_done = (state == ST_STOP) & bit_tick;

endmodule

`default_nettype wire

//--- source/uart_tx_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx_shifter
    import uart_tx_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,

    // Frame load from the FIFO head
    input  logic                  load,
    input  logic [DATA_WIDTH-1:0] data,

    // Shift control
    input  logic                  shift_en,
    input  logic                  bit_tick,

    // Serial line
    output logic                  tx_serial
);

    logic [FRAME_BITS-1:0] frame;

    // All ones keeps the line at the idle level
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            frame <= '1;
        end else if (load) begin
            // Stop bit on top, start bit goes out first
            frame <= {1'b1, data, 1'b0};
        end else if (shift_en && bit_tick) begin
            frame <= {1'b1, frame[FRAME_BITS-1:1]};
        end
    end

    // LSB first onto the wire
    assign tx_serial = frame[0];

endmodule

`default_nettype wire

//--- source/uart_tx_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx_datapath
    import uart_tx_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,

    // FIFO write port
    input  logic                  wr_en,
    input  logic [DATA_WIDTH-1:0] wr_data,
    output logic                  full,
    output logic                  almost_full,

    // Transmit control and status
    input  logic                  tx_valid,
    output logic                  tx_ready,
    output logic                  tx_busy,
    output logic                  tx_done,
    output logic                  tx_serial
);

    logic [DATA_WIDTH-1:0] rd_data;
    logic                  empty;
    logic                  fifo_pop;
    logic                  bit_tick;
    logic                  shift_en;

    uart_tx_fifo u_fifo (
        .clk         (clk),
        .arst_n      (arst_n),
        .wr_en       (wr_en),
        .wr_data     (wr_data),
        .rd_en       (fifo_pop),
        .rd_data     (rd_data),
        .full        (full),
        .almost_full (almost_full),
        .empty       (empty)
    );

    // Bit period starts over at every pop
    uart_baud_timer u_baud (
        .clk      (clk),
        .arst_n   (arst_n),
        .restart  (fifo_pop),
        .bit_tick (bit_tick)
    );

    uart_tx_controller u_ctrl (
        .clk      (clk),
        .arst_n   (arst_n),
        .tx_valid (tx_valid),
        .empty    (empty),
        .bit_tick (bit_tick),
        .fifo_pop (fifo_pop),
        .shift_en (shift_en),
        .tx_ready (tx_ready),
        .tx_busy  (tx_busy),
        .tx_done  (tx_done)
    );

    // Captures the FIFO head in the same cycle it is popped
    uart_tx_shifter u_shift (
        .clk       (clk),
        .arst_n    (arst_n),
        .load      (fifo_pop),
        .data      (rd_data),
        .shift_en  (shift_en),
        .bit_tick  (bit_tick),
        .tx_serial (tx_serial)
    );

endmodule

`default_nettype wire

//--- bench/uart_tx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx_tb
    import uart_tx_pkg::*;
();

    localparam int CLK_PERIOD    = 40;
    localparam int DRIVE_DELAY   = 2;
    localparam int FRAME_CLKS    = FRAME_BITS * CLKS_PER_BIT;
    localparam int START_TIMEOUT = 2 * FRAME_CLKS;
    localparam int RANDOM_BYTES  = 20;

    logic                  clk;
    logic                  arst_n;
    logic                  wr_en;
    logic [DATA_WIDTH-1:0] wr_data;
    logic                  full;
    logic                  almost_full;
    logic                  tx_valid;
    logic                  tx_ready;
    logic                  tx_busy;
    logic                  tx_done;
    logic                  tx_serial;

    // Expected FIFO contents in line order
    logic [DATA_WIDTH-1:0] exp_q [$];
    int                    done_count = 0;

    uart_tx_datapath UUT (
        .clk         (clk),
        .arst_n      (arst_n),
        .wr_en       (wr_en),
        .wr_data     (wr_data),
        .full        (full),
        .almost_full (almost_full),
        .tx_valid    (tx_valid),
        .tx_ready    (tx_ready),
        .tx_busy     (tx_busy),
        .tx_done     (tx_done),
        .tx_serial   (tx_serial)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Completed frames counted on the falling edge
    always @(negedge clk) begin
        if (tx_done === 1'b1) begin
            done_count <= done_count + 1;
        end
    end

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                           input string msg);
        if (actual !== expected) begin
            $display("FAIL at %0t: %s, got 0x%0h, expected 0x%0h",
                     $time, msg, actual, expected);
            stop_run();
        end
    endtask

    task automatic timed_out(input string what);
        $display("ERROR at %0t: timed out waiting for %s", $time, what);
        stop_run();
    endtask

    task automatic set_valid(input logic level);
        @(posedge clk);
        #DRIVE_DELAY;
        tx_valid = level;
    endtask

    task automatic write_byte(input logic [DATA_WIDTH-1:0] data);
        @(posedge clk);
        #DRIVE_DELAY;
        wr_en   = 1'b1;
        wr_data = data;
        @(posedge clk);
        #DRIVE_DELAY;
        wr_en = 1'b0;
        // Taken on the edge just passed unless the FIFO was already full
        if (exp_q.size() < FIFO_DEPTH) begin
            exp_q.push_back(data);
        end
    endtask

    task automatic receive_frame(output logic [DATA_WIDTH-1:0] data,
                                 output logic [DATA_WIDTH-1:0] expected);
        int waited;
        int i;
        waited = 0;
        @(negedge clk);
        while (tx_serial !== 1'b0) begin
            if (waited >= START_TIMEOUT) begin
                timed_out("a start bit on tx_serial");
            end
            waited++;
            @(negedge clk);
        end
        if (exp_q.size() == 0) begin
            $display("ERROR at %0t: a frame started with no byte written", $time);
            stop_run();
        end
        // The FIFO has already popped this byte
        expected = exp_q.pop_front();

        // Middle of the start bit
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        compare(tx_serial, 1'b0, "start bit level");
        compare(tx_busy, 1'b1, "tx_busy during start bit");

        for (i = 0; i < DATA_WIDTH; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            data[i] = tx_serial;
            compare(tx_busy, 1'b1, $sformatf("tx_busy during data bit %0d", i));
        end

        repeat (CLKS_PER_BIT) @(negedge clk);
        compare(tx_serial, 1'b1, "stop bit level");
        compare(tx_busy, 1'b1, "tx_busy during stop bit");
    endtask

    task automatic wait_until_idle();
        int waited;
        waited = 0;
        @(negedge clk);
        while (tx_busy !== 1'b0) begin
            if (waited >= 2 * FRAME_CLKS) begin
                timed_out("the transmitter to go idle");
            end
            waited++;
            @(negedge clk);
        end
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        compare(tx_serial, 1'b1, "tx_serial after reset");
        compare(tx_ready, 1'b1, "tx_ready after reset");
        compare(tx_busy, 1'b0, "tx_busy after reset");
        compare(tx_done, 1'b0, "tx_done after reset");
        compare(full, 1'b0, "full after reset");
        compare(almost_full, 1'b0, "almost_full after reset");
    endtask

    task automatic send_single_frame();
        logic [DATA_WIDTH-1:0] got;
        logic [DATA_WIDTH-1:0] want;
        int                    done_before;
        done_before = done_count;
        set_valid(1'b1);
        write_byte(8'ha5);
        receive_frame(got, want);
        compare(got, want, "single frame byte");
        wait_until_idle();
        compare(done_count - done_before, 1, "tx_done pulses for one frame");
        compare(tx_ready, 1'b1, "tx_ready after single frame");
        set_valid(1'b0);
    endtask

    task automatic hold_by_valid();
        logic [DATA_WIDTH-1:0] got;
        logic [DATA_WIDTH-1:0] want;
        int                    n;
        write_byte(8'h3c);
        write_byte(8'hc3);
        write_byte(8'h81);
        // Nothing may leave while tx_valid is low
        repeat (3 * CLKS_PER_BIT) begin
            @(negedge clk);
            compare(tx_serial, 1'b1, "line idle while tx_valid low");
            compare(tx_ready, 1'b1, "tx_ready while tx_valid low");
        end
        set_valid(1'b1);
        for (n = 0; n < 3; n++) begin
            receive_frame(got, want);
            compare(got, want, $sformatf("held byte %0d", n));
        end
        wait_until_idle();
        compare(tx_ready, 1'b1, "tx_ready after held bytes");
        set_valid(1'b0);
    endtask

    task automatic fill_and_overflow();
        logic [DATA_WIDTH-1:0] got;
        logic [DATA_WIDTH-1:0] want;
        int                    n;
        int                    done_before;
        for (n = 1; n <= FIFO_DEPTH + 1; n++) begin
            write_byte(DATA_WIDTH'(8'h40 + n));
            @(negedge clk);
            compare(almost_full, n >= ALMOST_FULL_LEVEL,
                    $sformatf("almost_full after write %0d", n));
            compare(full, n >= FIFO_DEPTH, $sformatf("full after write %0d", n));
        end

        done_before = done_count;
        set_valid(1'b1);
        for (n = 0; n < FIFO_DEPTH; n++) begin
            receive_frame(got, want);
            compare(got, want, $sformatf("byte %0d from a full FIFO", n));
        end
        // The dropped byte must never show up
        repeat (2 * FRAME_CLKS) begin
            @(negedge clk);
            compare(tx_serial, 1'b1, "line idle after FIFO drained");
        end
        compare(done_count - done_before, FIFO_DEPTH, "tx_done count for full FIFO");
        compare(tx_busy, 1'b0, "tx_busy after FIFO drained");
        compare(full, 1'b0, "full after FIFO drained");
        set_valid(1'b0);
    endtask

    task automatic feed_random_bytes(input int count);
        int                    n;
        int                    waited;
        logic [DATA_WIDTH-1:0] data;
        for (n = 0; n < count; n++) begin
            waited = 0;
            @(negedge clk);
            while (full !== 1'b0) begin
                if (waited >= 2 * FRAME_CLKS) begin
                    timed_out("room in the FIFO");
                end
                waited++;
                @(negedge clk);
            end
            data = DATA_WIDTH'($urandom);
            write_byte(data);
        end
    endtask

    task automatic collect_frames(input int count);
        logic [DATA_WIDTH-1:0] got;
        logic [DATA_WIDTH-1:0] want;
        int                    n;
        for (n = 0; n < count; n++) begin
            receive_frame(got, want);
            compare(got, want, $sformatf("random byte %0d", n));
        end
    endtask

    task automatic stream_random_bytes();
        int done_before;
        done_before = done_count;
        set_valid(1'b1);
        fork
            feed_random_bytes(RANDOM_BYTES);
            collect_frames(RANDOM_BYTES);
        join
        // Busy must drop once the last frame ends
        wait_until_idle();
        compare(done_count - done_before, RANDOM_BYTES, "tx_done count for random traffic");
        set_valid(1'b0);
    endtask

    initial begin
        int unsigned first_draw;
        arst_n   = 1'b0;
        wr_en    = 1'b0;
        wr_data  = '0;
        tx_valid = 1'b0;
        first_draw = $urandom(32'h5111_407a);

        repeat (10) @(posedge clk);
        #DRIVE_DELAY;
        arst_n = 1'b1;

        check_reset_state();
        send_single_frame();
        hold_by_valid();
        fill_and_overflow();
        stream_random_bytes();

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
source/uart_tx_pkg.sv
source/uart_tx_fifo.sv
source/uart_baud_timer.sv
source/uart_tx_controller.sv
source/uart_tx_shifter.sv
source/uart_tx_datapath.sv
bench/uart_tx_tb.sv
